//--- logic/pc_types_pkg.sv
package pc_types_pkg;

	// Widths used on the internal buses and the external address
	typedef logic [7:0]  byte_t;	// One bus byte, PCL or PCH
	typedef logic [15:0] addr_t;	// PCH:PCL or address bus

	// PC value after reset
	localparam addr_t PC_RESET = 16'h0000;

	// Data out register after reset
	localparam byte_t DATA_RESET = 8'h00;

	// Value read from a bus that nobody drives
	localparam byte_t BUS_IDLE = 8'hFF;	// Precharged high

endpackage

//--- logic/pc_ctrl_pkg.sv
package pc_ctrl_pkg;

	// External command, sampled with cmd_valid
	typedef enum logic [1:0] {
		CMD_NOP   = 2'd0,
		CMD_FETCH = 2'd1,	// PC to address bus, then increment
		CMD_JUMP  = 2'd2,	// PCL then PCH from data_in
		CMD_PUSH  = 2'd3	// PCH then PCL to data_out
	} pc_cmd_e;

	// Sequencer steps, one per cycle
	typedef enum logic [2:0] {
		S_IDLE    = 3'd0,
		S_FETCH   = 3'd1,
		S_JUMP_LO = 3'd2,
		S_JUMP_HI = 3'd3,
		S_PUSH_HI = 3'd4,
		S_PUSH_LO = 3'd5
	} seq_state_e;

endpackage

//--- logic/pc_ctrl_if.sv
interface pc_ctrl_if;

	logic adl_pcl;	// Shadow PCL from ADL
	logic pcl_pcl;	// Shadow PCL holds PCL
	logic adh_pch;	// Shadow PCH from ADH
	logic pch_pch;	// Shadow PCH holds PCH
	logic pcl_adl;	// PCL drives ADL
	logic pch_adh;	// PCH drives ADH
	logic pcl_db;
	logic pch_db;
	logic ipc;	// Increment PC
	logic din_adl;	// data_in drives ADL
	logic din_adh;
	logic ab_load;	// Address registers take ADH:ADL
	logic db_write;	// Data out register takes DB

	modport seq (
		output adl_pcl, pcl_pcl, adh_pch, pch_pch,
		output pcl_adl, pch_adh, pcl_db, pch_db,
		output ipc, din_adl, din_adh, ab_load, db_write
	);

	modport pc (
		input adl_pcl, pcl_pcl, adh_pch, pch_pch,
		input pcl_adl, pch_adh, pcl_db, pch_db,
		input ipc, din_adl, din_adh, ab_load, db_write
	);

endinterface

//--- logic/pc_unit.sv
module pc_unit (
	input  logic                phi2,
	input  logic                arst_n,
	pc_ctrl_if.pc               ctl,
	input  pc_types_pkg::byte_t adl,
	input  pc_types_pkg::byte_t adh,
	output pc_types_pkg::byte_t pcl,
	output pc_types_pkg::byte_t pch
);
	import pc_types_pkg::*;

	byte_t pcl_s;	// PCLS shadow
	byte_t pch_s;	// PCHS shadow
	logic  pcl_src;	// Some source drives PCLS
	logic  pch_src;
	logic  pclc;	// PCL all ones, carry into PCH
	logic  pchc;	// Low PCH nibble all ones too
	byte_t pcl_next;
	byte_t pch_next;

	// Shadow latches follow the bus or the current PC half
	always_comb begin
		pcl_src = ctl.adl_pcl | ctl.pcl_pcl;
		pch_src = ctl.adh_pch | ctl.pch_pch;
		pcl_s = ctl.adl_pcl ? adl : pcl;
		pch_s = ctl.adh_pch ? adh : pch;
	end

	// Three carry groups over PCL, PCH[3:0] and PCH[7:4]
	assign pclc = ctl.ipc & (&pcl_s);
	assign pchc = pclc & (&pch_s[3:0]);

	assign pcl_next = pcl_s + {7'd0, ctl.ipc};	// Wraps at 0xFF
	assign pch_next = {pch_s[7:4] + {3'd0, pchc}, pch_s[3:0] + {3'd0, pclc}};

	// With no source the latch floats, so the PC half keeps its value
	always_ff @(posedge phi2 or negedge arst_n) begin
		if (!arst_n) begin
			pcl <= PC_RESET[7:0];
		end else if (pcl_src) begin
			pcl <= pcl_next;
		end
	end

	always_ff @(posedge phi2 or negedge arst_n) begin
		if (!arst_n) begin
			pch <= PC_RESET[15:8];
		end else if (pch_src) begin
			pch <= pch_next;	// 0xFFFF wraps to 0x0000
		end
	end

endmodule

//--- logic/bus_fabric.sv
module bus_fabric (
	pc_ctrl_if.pc               ctl,
	input  pc_types_pkg::byte_t pcl,
	input  pc_types_pkg::byte_t pch,
	input  pc_types_pkg::byte_t data_in,
	output pc_types_pkg::byte_t adl,
	output pc_types_pkg::byte_t adh,
	output pc_types_pkg::byte_t db
);
	import pc_types_pkg::*;

	// PC drive wins over external data
	always_comb begin
		if (ctl.pcl_adl) begin
			adl = pcl;
		end else if (ctl.din_adl) begin
			adl = data_in;
		end else begin
			adl = BUS_IDLE;
		end
	end

	always_comb begin
		if (ctl.pch_adh) begin
			adh = pch;
		end else if (ctl.din_adh) begin
			adh = data_in;
		end else begin
			adh = BUS_IDLE;
		end
	end

	// Only the PC halves drive DB here
	always_comb begin
		if (ctl.pcl_db) begin
			db = pcl;
		end else if (ctl.pch_db) begin
			db = pch;
		end else begin
			db = BUS_IDLE;
		end
	end

endmodule

//--- logic/address_bus_reg.sv
module address_bus_reg (
	input  logic                phi2,
	input  logic                arst_n,
	pc_ctrl_if.pc               ctl,
	input  pc_types_pkg::byte_t adl,
	input  pc_types_pkg::byte_t adh,
	input  pc_types_pkg::byte_t db,
	output pc_types_pkg::addr_t addr,
	output pc_types_pkg::byte_t data_out,
	output logic                data_we
);
	import pc_types_pkg::*;

	// ABH:ABL registers
	always_ff @(posedge phi2 or negedge arst_n) begin
		if (!arst_n) begin
			addr <= PC_RESET;
		end else if (ctl.ab_load) begin
			addr <= {adh, adl};
		end
	end

	// Data out register and its write strobe
	always_ff @(posedge phi2 or negedge arst_n) begin
		if (!arst_n) begin
			data_out <= DATA_RESET;
			data_we  <= 1'b0;
		end else begin
			data_we <= ctl.db_write;	// High in the cycle after the load
			if (ctl.db_write) begin
				data_out <= db;
			end
		end
	end

endmodule

//--- logic/pc_sequencer.sv
module pc_sequencer (
	input  logic                 phi2,
	input  logic                 arst_n,
	input  logic                 cmd_valid,
	input  pc_ctrl_pkg::pc_cmd_e cmd,
	output logic                 done,
	pc_ctrl_if.seq               ctl
);
	import pc_ctrl_pkg::*;

	seq_state_e state;
	seq_state_e state_next;
	logic       last_step;	// Final step of any command

	always_ff @(posedge phi2 or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_IDLE;
			done  <= 1'b0;
		end else begin
			state <= state_next;
			done  <= last_step;
		end
	end

	// Commands are taken in IDLE only and strobes while busy are lost
	always_comb begin
		state_next = S_IDLE;
		case (state)
			S_IDLE: begin
				if (cmd_valid) begin
					case (cmd)
						CMD_FETCH: state_next = S_FETCH;
						CMD_JUMP:  state_next = S_JUMP_LO;
						CMD_PUSH:  state_next = S_PUSH_HI;
						default:   state_next = S_IDLE;
					endcase
				end
			end
			S_JUMP_LO: state_next = S_JUMP_HI;
			S_PUSH_HI: state_next = S_PUSH_LO;
			default:   state_next = S_IDLE;	// FETCH, JUMP_HI, PUSH_LO end here
		endcase
	end

	assign last_step = (state == S_FETCH) || (state == S_JUMP_HI) || (state == S_PUSH_LO);

	// Per step bus controls
	always_comb begin
		ctl.adl_pcl  = 1'b0;
		ctl.pcl_pcl  = 1'b0;
		ctl.adh_pch  = 1'b0;
		ctl.pch_pch  = 1'b0;
		ctl.pcl_adl  = 1'b0;
		ctl.pch_adh  = 1'b0;
		ctl.pcl_db   = 1'b0;
		ctl.pch_db   = 1'b0;
		ctl.ipc      = 1'b0;
		ctl.din_adl  = 1'b0;
		ctl.din_adh  = 1'b0;
		ctl.ab_load  = 1'b0;
		ctl.db_write = 1'b0;
		case (state)
			S_FETCH: begin
				ctl.pcl_pcl = 1'b1;
				ctl.pch_pch = 1'b1;
				ctl.pcl_adl = 1'b1;
				ctl.pch_adh = 1'b1;
				ctl.ab_load = 1'b1;	// Old PC to the address bus
				ctl.ipc     = 1'b1;
			end
			S_JUMP_LO: begin
				ctl.din_adl = 1'b1;
				ctl.adl_pcl = 1'b1;
				ctl.pch_pch = 1'b1;
			end
			S_JUMP_HI: begin
				ctl.din_adh = 1'b1;
				ctl.adh_pch = 1'b1;
				ctl.pcl_pcl = 1'b1;
			end
			S_PUSH_HI, S_PUSH_LO: begin
				ctl.pcl_pcl  = 1'b1;
				ctl.pch_pch  = 1'b1;
				ctl.pch_db   = (state == S_PUSH_HI);	// PCH goes out first
				ctl.pcl_db   = (state == S_PUSH_LO);
				ctl.db_write = 1'b1;
			end
			default: ;	// Idle keeps every control low
		endcase
	end

endmodule

//--- logic/pc_subsystem.sv
module pc_subsystem (
	input  logic                 phi2,
	input  logic                 arst_n,
	input  logic                 cmd_valid,
	input  pc_ctrl_pkg::pc_cmd_e cmd,
	input  pc_types_pkg::byte_t  data_in,
	output pc_types_pkg::addr_t  addr,
	output pc_types_pkg::byte_t  data_out,
	output logic                 data_we,
	output logic                 done
);
	import pc_types_pkg::*;

	byte_t adl;	// Internal address low bus
	byte_t adh;
	byte_t db;	// Internal data bus
	byte_t pcl;
	byte_t pch;

	pc_ctrl_if ctl_bus ();

	pc_sequencer u_seq (
		.phi2      (phi2),
		.arst_n    (arst_n),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.done      (done),
		.ctl       (ctl_bus)
	);

	bus_fabric u_fabric (
		.ctl     (ctl_bus),
		.pcl     (pcl),
		.pch     (pch),
		.data_in (data_in),
		.adl     (adl),
		.adh     (adh),
		.db      (db)
	);

	pc_unit u_pc (
		.phi2   (phi2),
		.arst_n (arst_n),
		.ctl    (ctl_bus),
		.adl    (adl),
		.adh    (adh),
		.pcl    (pcl),
		.pch    (pch)
	);

	address_bus_reg u_abus (
		.phi2     (phi2),
		.arst_n   (arst_n),
		.ctl      (ctl_bus),
		.adl      (adl),
		.adh      (adh),
		.db       (db),
		.addr     (addr),
		.data_out (data_out),
		.data_we  (data_we)
	);

endmodule

//--- bench/tb_pc_subsystem.sv
module tb_pc_subsystem;
	timeunit 1ns;
	timeprecision 100ps;
	import pc_types_pkg::*;
	import pc_ctrl_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int N_DIRECTED = 17;	// Commands in the directed part
	localparam int N_RANDOM   = 200;
	localparam int CMD_CYCLES = 4;	// Longest command plus its gap
	localparam int TIMEOUT    = (N_DIRECTED + N_RANDOM) * CMD_CYCLES * CLK_PERIOD + 200;

	logic    phi2;
	logic    arst_n;
	logic    cmd_valid;
	pc_cmd_e cmd;
	byte_t   data_in;
	addr_t   addr;
	byte_t   data_out;
	logic    data_we;
	logic    done;

	addr_t       pc_model;	// Reference PC
	logic [31:0] rng;

	pc_subsystem u_dut (
		.phi2      (phi2),
		.arst_n    (arst_n),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.data_in   (data_in),
		.addr      (addr),
		.data_out  (data_out),
		.data_we   (data_we),
		.done      (done)
	);

	initial begin
		phi2 = 1'b0;
		forever #(CLK_PERIOD / 2) phi2 = ~phi2;
	end

	initial begin
		#(TIMEOUT);
		$display("Timeout: the run hung, a command never finished in time");
		$display("sim failed");
		$fatal(1, "watchdog expired");
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic fail_value(input string name, input logic [15:0] exp, input logic [15:0] act);
		$display("FAILED %s: expected 0x%04h, actual 0x%04h", name, exp, act);
		$display("sim failed");
		$fatal(1, "mismatch in %s", name);
	endtask

	task automatic check_strobes(input string name, input logic exp_done, input logic exp_we);
		assert (done === exp_done) else fail_value({name, " done"}, exp_done, done);
		assert (data_we === exp_we) else fail_value({name, " data_we"}, exp_we, data_we);
	endtask

	// Called on a falling edge and returns on the one after the sampling edge
	task automatic issue(input pc_cmd_e c);
		cmd_valid = 1'b1;
		cmd       = c;
		@(negedge phi2);
		cmd_valid = 1'b0;
		cmd       = CMD_NOP;
	endtask

	// A strobe the busy sequencer must ignore
	task automatic busy_strobe();
		rng       = xorshift(rng);
		cmd_valid = 1'b1;
		cmd       = (rng[1:0] == 2'd0) ? CMD_FETCH : pc_cmd_e'(rng[1:0]);
	endtask

	task automatic idle(input string name, input int n);
		repeat (n) begin
			@(negedge phi2);
			check_strobes(name, 1'b0, 1'b0);
		end
	endtask

	task automatic fetch_once(input string name);
		issue(CMD_FETCH);
		check_strobes(name, 1'b0, 1'b0);
		@(negedge phi2);
		check_strobes(name, 1'b1, 1'b0);
		assert (addr === pc_model) else fail_value({name, " addr"}, pc_model, addr);
		pc_model = pc_model + 16'd1;	// Wraps at 0xFFFF
	endtask

	task automatic jump_to(input string name, input addr_t target, input logic drop);
		issue(CMD_JUMP);
		data_in = target[7:0];	// Low byte first
		if (drop) begin
			busy_strobe();
		end
		check_strobes(name, 1'b0, 1'b0);
		@(negedge phi2);
		cmd_valid = 1'b0;
		cmd       = CMD_NOP;
		data_in   = target[15:8];
		check_strobes(name, 1'b0, 1'b0);
		@(negedge phi2);
		data_in = 8'h00;
		check_strobes(name, 1'b1, 1'b0);
		pc_model = target;
	endtask

	task automatic push_pc(input string name, input logic drop);
		issue(CMD_PUSH);
		check_strobes(name, 1'b0, 1'b0);
		@(negedge phi2);
		if (drop) begin
			busy_strobe();	// Lands on the PUSH_LO step
		end
		check_strobes(name, 1'b0, 1'b1);
		assert (data_out === pc_model[15:8])
			else fail_value({name, " pch"}, pc_model[15:8], data_out);
		@(negedge phi2);
		cmd_valid = 1'b0;
		cmd       = CMD_NOP;
		check_strobes(name, 1'b1, 1'b1);
		assert (data_out === pc_model[7:0])
			else fail_value({name, " pcl"}, pc_model[7:0], data_out);
	endtask

	initial begin
		cmd_valid = 1'b0;
		cmd       = CMD_NOP;
		data_in   = 8'h00;
		arst_n    = 1'b0;
		rng       = 32'd92603;
		pc_model  = PC_RESET;
		repeat (3) @(negedge phi2);
		arst_n = 1'b1;
		@(negedge phi2);
		check_strobes("reset", 1'b0, 1'b0);
		assert (addr === PC_RESET) else fail_value("reset addr", PC_RESET, addr);
		assert (data_out === 8'h00) else fail_value("reset data_out", 16'h0000, data_out);

		fetch_once("fetch_first");
		fetch_once("fetch_second");
		jump_to("jump_wrap", 16'hFFFE, 1'b0);
		repeat (3) fetch_once("fetch_wrap");	// FFFE, FFFF, 0000
		jump_to("jump_nibble", 16'h0FFE, 1'b1);
		repeat (3) fetch_once("fetch_nibble");
		jump_to("jump_byte", 16'h12FF, 1'b0);
		repeat (2) fetch_once("fetch_byte");
		push_pc("push", 1'b0);
		fetch_once("fetch_after_push");
		push_pc("push_drop", 1'b1);
		fetch_once("fetch_after_drop");

		for (int i = 0; i < N_RANDOM; i++) begin
			rng = xorshift(rng);
			case (rng[1:0])
				2'd0, 2'd1: fetch_once("rand_fetch");
				2'd2:       jump_to("rand_jump", addr_t'(rng[31:16]), rng[2]);
				default:    push_pc("rand_push", rng[2]);
			endcase
			idle("rand_gap", int'(rng[3]));
		end

		idle("final_idle", 3);
		$display("sim passed");
		$finish;
	end

endmodule

//--- project.f
logic/pc_types_pkg.sv
logic/pc_ctrl_pkg.sv
logic/pc_ctrl_if.sv
logic/pc_unit.sv
logic/bus_fabric.sv
logic/address_bus_reg.sv
logic/pc_sequencer.sv
logic/pc_subsystem.sv
bench/tb_pc_subsystem.sv

//--- Bender.yml
package:
  name: pc_subsystem

sources:
  - logic/pc_types_pkg.sv
  - logic/pc_ctrl_pkg.sv
  - logic/pc_ctrl_if.sv
  - logic/pc_unit.sv
  - logic/bus_fabric.sv
  - logic/address_bus_reg.sv
  - logic/pc_sequencer.sv
  - logic/pc_subsystem.sv
  - target: test
    files:
      - bench/tb_pc_subsystem.sv
